// ==== hdl/simd_macros.svh ====
// Sizing macros for the SIMD result wrapper
// Lane count, word and tag widths, queue depth and threshold

`ifndef SIMD_MACROS_SVH
`define SIMD_MACROS_SVH

// --------------------
// Lanes

// Number of execution lanes in the processing element
`define SIMD_LANES 4

// Width of one lane result word
`define SIMD_LANE_WIDTH 32

// --------------------
// Tags

// Operation tag carried upstream with the lane words
`define SIMD_TAG_WIDTH 8

// --------------------
// Queues

// Storage entries per queue, excluding the two prefetch stages
`define SIMD_QUEUE_DEPTH 8

// Ready drops at this occupancy
// Leaves room for the ingress register and words already in flight
`define SIMD_QUEUE_THRESHOLD 5

`endif

// ==== hdl/simd_pkg.sv ====
// Shared types for the SIMD result wrapper
// Vector typedefs, packed bundles and the sender FSM states

`include "simd_macros.svh"

package simd_pkg;

  // Plain vectors with a meaning
  typedef logic [`SIMD_LANE_WIDTH-1:0] lane_word_t;
  typedef logic [`SIMD_TAG_WIDTH-1:0]  tag_t;
  typedef logic [`SIMD_LANES-1:0]      lane_mask_t;
  // One word per lane with lane 0 in the low bits
  typedef lane_word_t [`SIMD_LANES-1:0] lane_words_t;

  // One cycle of lane results from the streaming operations
  typedef struct packed {
    lane_mask_t  valid;
    lane_words_t data;
  } lane_results_t;

  // One tag from the controller
  typedef struct packed {
    logic valid;
    tag_t tag;
  } tag_beat_t;

  // What goes to the upstream stack interface
  typedef struct packed {
    lane_mask_t  valid;
    tag_t        tag;
    lane_words_t data;
  } upstream_beat_t;

  // Status back from the upstream side
  typedef struct packed {
    logic ready;
    logic complete;
  } upstream_status_t;

  // Upstream handshake FSM
  typedef enum logic [2:0] {
    WAIT,
    SEND,
    WAIT_COMPLETE,
    WAIT_RELEASE,
    DONE
  } sender_state_t;

endpackage

// ==== hdl/result_ingress.sv ====
// Input register stage of the SIMD wrapper
// Registers lane results, controller tags and upstream status

`timescale 1ns/1ns

module result_ingress
  import simd_pkg::*;
(
  input  logic             clk,
  input  logic             arst_n,
  input  lane_results_t    results,
  input  tag_beat_t        tag_in,
  input  upstream_status_t status_in,
  output lane_results_t    results_q,
  output tag_beat_t        tag_q,
  output upstream_status_t status_q
);

  // Control half of each bundle
  lane_mask_t       lane_valid_q;
  logic             tag_valid_q;
  upstream_status_t status_r;

  // Payload half of each bundle
  lane_words_t      lane_data_q;
  tag_t             tag_data_q;

  // --------------------
  // Valids and status

  always_ff @(posedge clk or negedge arst_n)
  begin
    if (!arst_n)
    begin
      lane_valid_q <= '0;
      tag_valid_q  <= 1'b0;
      status_r     <= '0;
    end
    else
    begin
      lane_valid_q <= results.valid;
      tag_valid_q  <= tag_in.valid;
      // Upstream ready and complete seen by the FSM one cycle late
      status_r     <= status_in;
    end
  end

  // --------------------
  // Payload

  // Lane words and tag
  always_ff @(posedge clk)
  begin
    lane_data_q <= results.data;
    tag_data_q  <= tag_in.tag;
  end

  // Rebuild the bundles for the queue write ports
  assign results_q.valid = lane_valid_q;
  assign results_q.data  = lane_data_q;
  assign tag_q.valid     = tag_valid_q;
  assign tag_q.tag       = tag_data_q;
  assign status_q        = status_r;

endmodule

// ==== hdl/result_queue.sv ====
// Result queue with almost-full ready
// Circular buffer followed by a two-stage self-charging prefetch pipe
// Used for every lane and for the tag

`timescale 1ns/1ns

`include "simd_macros.svh"

module result_queue #(
  parameter int WIDTH = `SIMD_LANE_WIDTH
) (
  input  logic             clk,
  input  logic             arst_n,
  input  logic             push,
  input  logic [WIDTH-1:0] push_data,
  output logic             ready,
  output logic             head_valid,
  output logic [WIDTH-1:0] head_data,
  input  logic             pop
);

  localparam int DEPTH   = `SIMD_QUEUE_DEPTH;
  localparam int ADDR_W  = $clog2(DEPTH);
  localparam int COUNT_W = $clog2(DEPTH + 1);

  // Storage
  logic [WIDTH-1:0]   mem [DEPTH];
  logic [ADDR_W-1:0]  wr_ptr;
  logic [ADDR_W-1:0]  rd_ptr;
  logic [COUNT_W-1:0] count;
  logic               empty;
  logic               full;
  logic               wr_en;
  logic               rd_en;

  // First prefetch stage holding the registered buffer read
  logic               s1_valid;
  logic [WIDTH-1:0]   s1_data;
  logic               s1_move;

  assign empty = (count == '0);
  assign full  = (count == COUNT_W'(DEPTH));

  // Back-pressure from stored occupancy only
  assign ready = (count < COUNT_W'(`SIMD_QUEUE_THRESHOLD));

  // Drop a push into a full buffer rather than overwrite the oldest entry
  assign wr_en = push & ~full;

  // Keep the pipe charged
  // Read when stage one is empty or about to hand over
  assign rd_en   = ~empty & (~s1_valid | s1_move);
  // Stage one moves on when the head is empty or being popped
  assign s1_move = s1_valid & (~head_valid | pop);

  // --------------------
  // Pointers and occupancy

  always_ff @(posedge clk or negedge arst_n)
  begin
    if (!arst_n)
    begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end
    else
    begin
      if (wr_en)
        wr_ptr <= (wr_ptr == ADDR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      if (rd_en)
        rd_ptr <= (rd_ptr == ADDR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      // Simultaneous write and read leaves the count alone
      if (wr_en && !rd_en)
        count <= count + 1'b1;
      else if (!wr_en && rd_en)
        count <= count - 1'b1;
    end
  end

  // --------------------
  // Buffer and prefetch data

  always_ff @(posedge clk)
  begin
    if (wr_en)
      mem[wr_ptr] <= push_data;
    if (rd_en)
      s1_data <= mem[rd_ptr];
    if (s1_move)
      head_data <= s1_data;
  end

  // --------------------
  // Prefetch valids

  always_ff @(posedge clk or negedge arst_n)
  begin
    if (!arst_n)
    begin
      s1_valid   <= 1'b0;
      head_valid <= 1'b0;
    end
    else
    begin
      // A read refills stage one, else a hand-over empties it
      if (rd_en)
        s1_valid <= 1'b1;
      else if (s1_move)
        s1_valid <= 1'b0;
      // Same rule one stage later, with pop as the consumer
      if (s1_move)
        head_valid <= 1'b1;
      else if (pop)
        head_valid <= 1'b0;
    end
  end

endmodule

// ==== hdl/upstream_sender.sv ====
// Upstream sender of the SIMD wrapper
// Handshake FSM that pops all queues and builds the upstream beat

`timescale 1ns/1ns

module upstream_sender
  import simd_pkg::*;
(
  input  logic             clk,
  input  logic             arst_n,
  input  logic             tag_head_valid,
  input  tag_t             tag_head,
  input  lane_mask_t       lane_head_valid,
  input  lane_words_t      lane_heads,
  input  upstream_status_t status_q,
  output logic             pop,
  output upstream_beat_t   beat
);

  sender_state_t state;
  sender_state_t state_next;
  // Tag and a word from every lane sit at the queue heads
  logic          heads_ready;
  logic          send;

  assign heads_ready = tag_head_valid & (&lane_head_valid);
  assign send        = (state == SEND);

  // --------------------
  // State register

  always_ff @(posedge clk or negedge arst_n)
  begin
    if (!arst_n)
      state <= WAIT;
    else
      state <= state_next;
  end

  // --------------------
  // Next state

  always_comb
  begin
    state_next = state;
    case (state)
      // Start only when the upstream side can take a beat
      WAIT:
        if (heads_ready && status_q.ready)
          state_next = SEND;
      // Single-cycle valid pulse
      SEND:
        state_next = WAIT_COMPLETE;
      // Upstream raises complete once it has taken the beat
      WAIT_COMPLETE:
        if (status_q.complete)
          state_next = WAIT_RELEASE;
      // And lowers it before the next operation may go
      WAIT_RELEASE:
        if (!status_q.complete)
          state_next = DONE;
      DONE:
        state_next = WAIT;
      default:
        state_next = WAIT;
    endcase
  end

  // --------------------
  // Outputs

  // Heads stay put through SEND, pop takes effect at its end
  assign pop = send;

  always_comb
  begin
    beat.valid = {$bits(lane_mask_t){send}};
    beat.tag   = tag_head;
    beat.data  = lane_heads;
  end

endmodule

// ==== hdl/simd_wrapper.sv ====
// Top level of the SIMD result wrapper
// Ingress registers, per-lane result queues, tag queue and upstream sender

`timescale 1ns/1ns

`include "simd_macros.svh"

module simd_wrapper
  import simd_pkg::*;
(
  input  logic             clk,
  input  logic             arst_n,
  input  lane_results_t    results,
  input  tag_beat_t        tag_in,
  input  upstream_status_t status,
  output lane_mask_t       lane_ready,
  output logic             tag_ready,
  output upstream_beat_t   beat
);

  // Registered inputs
  lane_results_t    results_q;
  tag_beat_t        tag_q;
  upstream_status_t status_q;

  // Queue heads toward the sender
  lane_mask_t       lane_head_valid;
  lane_words_t      lane_heads;
  logic             tag_head_valid;
  tag_t             tag_head;

  // Shared pop for every queue
  logic             pop;

  // --------------------
  // Ingress

  result_ingress u_ingress (
    .clk       (clk),
    .arst_n    (arst_n),
    .results   (results),
    .tag_in    (tag_in),
    .status_in (status),
    .results_q (results_q),
    .tag_q     (tag_q),
    .status_q  (status_q)
  );

  // --------------------
  // Lane queues

  for (genvar i = 0; i < `SIMD_LANES; i++)
  begin : g_lane
    result_queue #(
      .WIDTH (`SIMD_LANE_WIDTH)
    ) u_lane_queue (
      .clk        (clk),
      .arst_n     (arst_n),
      .push       (results_q.valid[i]),
      .push_data  (results_q.data[i]),
      .ready      (lane_ready[i]),
      .head_valid (lane_head_valid[i]),
      .head_data  (lane_heads[i]),
      .pop        (pop)
    );
  end

  // Tag queue with the same structure at tag width
  result_queue #(
    .WIDTH (`SIMD_TAG_WIDTH)
  ) u_tag_queue (
    .clk        (clk),
    .arst_n     (arst_n),
    .push       (tag_q.valid),
    .push_data  (tag_q.tag),
    .ready      (tag_ready),
    .head_valid (tag_head_valid),
    .head_data  (tag_head),
    .pop        (pop)
  );

  // --------------------
  // Upstream handshake

  upstream_sender u_sender (
    .clk             (clk),
    .arst_n          (arst_n),
    .tag_head_valid  (tag_head_valid),
    .tag_head        (tag_head),
    .lane_head_valid (lane_head_valid),
    .lane_heads      (lane_heads),
    .status_q        (status_q),
    .pop             (pop),
    .beat            (beat)
  );

endmodule

// ==== testbench/simd_assert.sv ====
// Upstream handshake assertions for the SIMD wrapper
// Bound into simd_wrapper, checks the valid mask shape, its gating and reset value

`timescale 1ns/1ns

module simd_assert
  import simd_pkg::*;
(
  input logic             clk,
  input logic             arst_n,
  input upstream_status_t status,
  input upstream_beat_t   beat
);

  // A set mask covers all lanes and follows upstream ready two cycles earlier
  a_mask_whole : assert property (
    @(posedge clk) disable iff (!arst_n)
      (beat.valid != '0) |-> (beat.valid == '1) && $past(status.ready, 2)
  ) else $error("upstream valid mask partial or sent without upstream ready");

  // Single-cycle pulse
  a_pulse_single : assert property (
    @(posedge clk) disable iff (!arst_n)
      (beat.valid != '0) |=> (beat.valid == '0)
  ) else $error("upstream valid mask high for more than one cycle");

  // Nothing goes upstream while reset is applied
  a_reset_quiet : assert property (
    @(posedge clk)
      !arst_n |-> (beat.valid == '0)
  ) else $error("upstream valid mask set during reset");

endmodule

bind simd_wrapper simd_assert u_assert (
  .clk    (clk),
  .arst_n (arst_n),
  .status (status),
  .beat   (beat)
);

// ==== testbench/simd_tb.sv ====
// Testbench for the SIMD result wrapper
// Clock, reset, LCG stimulus, upstream responder, reference model and monitor

`timescale 1ns/1ns

`include "simd_macros.svh"

module simd_tb
  import simd_pkg::*;
();

  localparam int PUSH_TIMEOUT  = 1000;
  localparam int PULSE_TIMEOUT = 500;
  localparam int FULL_TIMEOUT  = 300;

  logic             clk;
  logic             arst_n;
  lane_results_t    results;
  tag_beat_t        tag_in;
  upstream_status_t status;
  lane_mask_t       lane_ready;
  logic             tag_ready;
  upstream_beat_t   beat;

  // Upstream ready requested by the test
  logic             ready_en;
  lane_word_t       rng_state = 32'd31;
  int               mismatches = 0;
  int               failures = 0;
  int               rx_count;
  string            test_name = "reset";

  // Every pushed operation in order with one entry per operation
  tag_t             tag_hist[$];
  lane_words_t      word_hist[$];

  simd_wrapper dut0 (
    .clk        (clk),
    .arst_n     (arst_n),
    .results    (results),
    .tag_in     (tag_in),
    .status     (status),
    .lane_ready (lane_ready),
    .tag_ready  (tag_ready),
    .beat       (beat)
  );

  // --------------------
  // Helpers

  // LCG with numerical recipes constants
  function automatic lane_word_t next_rand();
    rng_state = rng_state * 32'd1664525 + 32'd1013904223;
    return rng_state;
  endfunction

  // Operation n leaves with the nth tag and the nth word of every lane
  function automatic upstream_beat_t expected_beat(input int n);
    upstream_beat_t b;
    b.valid = '1;
    b.tag   = tag_hist[n];
    b.data  = word_hist[n];
    return b;
  endfunction

  task automatic report_failure(input string msg);
    failures++;
    $display("error in %s: %s", test_name, msg);
  endtask

  task automatic compare_tag(input string what, input tag_t expected, input tag_t actual);
    if (actual !== expected)
    begin
      mismatches++;
      $display("mismatch %s %s: expected %h actual %h", test_name, what, expected, actual);
    end
  endtask

  task automatic compare_word(input string what, input lane_word_t expected,
                              input lane_word_t actual);
    if (actual !== expected)
    begin
      mismatches++;
      $display("mismatch %s %s: expected %h actual %h", test_name, what, expected, actual);
    end
  endtask

  task automatic compare_mask(input string what, input lane_mask_t expected,
                              input lane_mask_t actual);
    if (actual !== expected)
    begin
      mismatches++;
      $display("mismatch %s %s: expected %b actual %b", test_name, what, expected, actual);
    end
  endtask

  task automatic compare_bit(input string what, input logic expected, input logic actual);
    if (actual !== expected)
    begin
      mismatches++;
      $display("mismatch %s %s: expected %b actual %b", test_name, what, expected, actual);
    end
  endtask

  task automatic check_count(input string what, input int expected, input int actual);
    if (actual != expected)
    begin
      mismatches++;
      $display("mismatch %s %s: expected %0d actual %0d", test_name, what, expected, actual);
    end
  endtask

  task automatic idle_cycles(input int n);
    repeat (n) @(posedge clk);
  endtask

  // Generate n operations, then push each queue on its own random schedule
  task automatic push_ops(input int n);
    int          base;
    int          lane_idx [`SIMD_LANES];
    int          tag_idx;
    int          cycles;
    logic        all_done;
    lane_word_t  r;
    lane_words_t w;
    base = tag_hist.size();
    for (int k = 0; k < n; k++)
    begin
      for (int i = 0; i < `SIMD_LANES; i++)
        w[i] = next_rand();
      r = next_rand();
      tag_hist.push_back(r[23:16]);
      word_hist.push_back(w);
    end
    for (int i = 0; i < `SIMD_LANES; i++)
      lane_idx[i] = 0;
    tag_idx  = 0;
    cycles   = 0;
    all_done = 1'b0;
    while (!all_done && cycles < PUSH_TIMEOUT)
    begin
      @(posedge clk);
      cycles++;
      // Schedule from the high bits since the low LCG bits repeat too soon
      r = next_rand();
      all_done = 1'b1;
      for (int i = 0; i < `SIMD_LANES; i++)
      begin
        results.valid[i] <= 1'b0;
        if (lane_idx[i] < n && lane_ready[i] && r[31-i])
        begin
          w = word_hist[base + lane_idx[i]];
          results.valid[i] <= 1'b1;
          results.data[i]  <= w[i];
          lane_idx[i]++;
        end
        if (lane_idx[i] < n)
          all_done = 1'b0;
      end
      tag_in.valid <= 1'b0;
      if (tag_idx < n && tag_ready && r[26])
      begin
        tag_in.valid <= 1'b1;
        tag_in.tag   <= tag_hist[base + tag_idx];
        tag_idx++;
      end
      if (tag_idx < n)
        all_done = 1'b0;
    end
    @(posedge clk);
    results.valid <= '0;
    tag_in.valid  <= 1'b0;
    if (!all_done)
      report_failure("timeout while pushing operations into the queues");
  endtask

  task automatic wait_pulses(input int target);
    int cycles;
    cycles = 0;
    while (rx_count < target && cycles < PULSE_TIMEOUT)
    begin
      @(posedge clk);
      cycles++;
    end
    if (rx_count < target)
      report_failure("timeout waiting for upstream pulses");
  endtask

  // Hold upstream not ready until every queue applies back-pressure
  task automatic release_on_full();
    int cycles;
    cycles = 0;
    while (!(lane_ready == '0 && !tag_ready) && cycles < FULL_TIMEOUT)
    begin
      @(posedge clk);
      cycles++;
    end
    if (lane_ready != '0 || tag_ready)
      report_failure("lane_ready and tag_ready did not both fall");
    @(posedge clk);
    ready_en <= 1'b1;
  endtask

  // --------------------
  // Clock

  initial
  begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  // --------------------
  // Upstream responder

  // Complete rises three cycles after a pulse and stays for two
  initial
  begin : responder
    int phase;
    phase = 0;
    status <= '0;
    forever
    begin
      @(posedge clk);
      status.ready <= ready_en;
      if (beat.valid != '0)
        phase = 1;
      else if (phase != 0)
        phase = (phase == 6) ? 0 : phase + 1;
      status.complete <= (phase == 3 || phase == 4);
    end
  end

  // --------------------
  // Monitor

  initial
  begin : monitor
    upstream_beat_t expected;
    logic           prev_pulse;
    logic           saw_complete;
    logic           released;
    prev_pulse   = 1'b0;
    saw_complete = 1'b0;
    released     = 1'b1;
    rx_count    <= 0;
    forever
    begin
      @(posedge clk);
      // Complete must go high then low between pulses
      if (status.complete)
        saw_complete = 1'b1;
      else if (saw_complete)
        released = 1'b1;
      if (beat.valid != '0)
      begin
        if (prev_pulse)
          report_failure("upstream valid held for more than one cycle");
        if (!released)
          report_failure("second pulse before complete was raised and lowered");
        if (rx_count >= tag_hist.size())
          report_failure("upstream pulse with no operation pending");
        else
        begin
          expected = expected_beat(rx_count);
          compare_mask("valid", expected.valid, beat.valid);
          compare_tag("tag", expected.tag, beat.tag);
          for (int i = 0; i < `SIMD_LANES; i++)
            compare_word($sformatf("lane %0d", i), expected.data[i], beat.data[i]);
        end
        rx_count    <= rx_count + 1;
        saw_complete = 1'b0;
        released     = 1'b0;
      end
      prev_pulse = (beat.valid != '0);
    end
  end

  // --------------------
  // Test sequence

  initial
  begin
    arst_n   <= 1'b0;
    results  <= '0;
    tag_in   <= '0;
    ready_en <= 1'b1;
    repeat (16) @(posedge clk);
    arst_n <= 1'b1;

    // Empty queues after reset
    idle_cycles(3);
    compare_mask("lane_ready", '1, lane_ready);
    compare_bit("tag_ready", 1'b1, tag_ready);
    idle_cycles(10);
    check_count("pulses", 0, rx_count);

    test_name = "single operation";
    push_ops(1);
    wait_pulses(1);
    idle_cycles(20);
    check_count("pulses", 1, rx_count);

    test_name = "ten operations";
    push_ops(10);
    wait_pulses(11);
    idle_cycles(20);
    check_count("pulses", 11, rx_count);

    test_name = "upstream not ready";
    @(posedge clk);
    ready_en <= 1'b0;
    push_ops(2);
    idle_cycles(30);
    check_count("pulses", 11, rx_count);

    // Keep pushing until the queues push back, then drain everything
    test_name = "back-pressure";
    fork
      push_ops(8);
      release_on_full();
    join
    wait_pulses(21);
    idle_cycles(30);
    check_count("pulses", tag_hist.size(), rx_count);

    $display("summary: %0d mismatches, %0d other errors", mismatches, failures);
    if (mismatches == 0 && failures == 0)
      $display("PASS: all tests");
    else
      $display("FAIL: see errors above");
    $finish;
  end

endmodule

// ==== project.f ====
+incdir+hdl
hdl/simd_pkg.sv
hdl/result_ingress.sv
hdl/result_queue.sv
hdl/upstream_sender.sv
hdl/simd_wrapper.sv
testbench/simd_assert.sv
testbench/simd_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Verilator build and run of the SIMD wrapper testbench

cd "$(dirname "$0")" || exit 1

verilator --binary --assert --top-module simd_tb -f project.f \
  || { echo "build failed"; exit 1; }

./obj_dir/Vsimd_tb > sim.log 2>&1
cat sim.log

grep -q "FAIL: see errors above" sim.log && { echo "simulation failed"; exit 1; }
grep -q "PASS: all tests" sim.log || { echo "simulation did not finish"; exit 1; }
echo "simulation passed"
